//--- hw/fletcher_cfg.svh
`ifndef FLETCHER_CFG_SVH
`define FLETCHER_CFG_SVH

// full checksum width
// b sits in the upper half and a in the lower half
`define FLETCHER_WIDTH 32

// entries in the command queue
`define CMD_QUEUE_DEPTH 4

// register byte offsets on the 4-bit AXI address
`define REG_CTRL     4'h0
`define REG_DATA     4'h4
`define REG_STATUS   4'h8
`define REG_CHECKSUM 4'hC

`endif

//--- hw/fletcherPkg.sv
`include "fletcher_cfg.svh"

package fletcherPkg;

    // one data halfword, half the checksum width
    typedef logic [`FLETCHER_WIDTH/2-1:0] halfWord_t;

    // result as {b, a}
    typedef logic [`FLETCHER_WIDTH-1:0] checksum_t;

    // what a queued command does to the sums
    typedef enum logic {
        cmdData  = 1'b0,
        cmdClear = 1'b1
    } cmdKind_t;

    // one queue entry
    // data is don't-care for a clear
    typedef struct packed {
        cmdKind_t  kind;
        halfWord_t data;
    } cmdEntry_t;

    // only the two AXI responses this slave ever gives
    typedef enum logic [1:0] {
        respOkay   = 2'd0,
        respSlvErr = 2'd2
    } axiResp_t;

endpackage

//--- hw/fletcherAccumulator.sv
`timescale 1ns/1ns
`include "fletcher_cfg.svh"

module fletcherAccumulator
    import fletcherPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      popValid,
    input  cmdEntry_t popEntry,
    output checksum_t checksum,
    output logic      pending
);
    localparam int HalfWidth = `FLETCHER_WIDTH / 2;
    // modulus is the all-ones halfword, 65535
    localparam logic [HalfWidth:0] Modulus = {1'b0, {HalfWidth{1'b1}}};

    // running sums, always kept in 0 .. modulus-1
    halfWord_t sumA;
    halfWord_t sumB;
    // delayed enable, b follows a by one cycle
    logic bUpdate;

    // widened sums and their once-reduced versions
    logic [HalfWidth:0] rawA;
    logic [HalfWidth:0] rawB;
    logic [HalfWidth:0] reducedA;
    logic [HalfWidth:0] reducedB;
    halfWord_t nextA;
    halfWord_t nextB;

    logic takeData;
    logic takeClear;

    assign takeData  = popValid && (popEntry.kind == cmdData);
    assign takeClear = popValid && (popEntry.kind == cmdClear);

    always_comb begin
        rawA = {1'b0, sumA} + {1'b0, popEntry.data};
        // b adds the a that was just written
        rawB = {1'b0, sumB} + {1'b0, sumA};
        reducedA = rawA - Modulus;
        reducedB = rawB - Modulus;
        // both operands below 2*modulus, one subtract is enough
        nextA = (rawA >= Modulus) ? reducedA[HalfWidth-1:0] : rawA[HalfWidth-1:0];
        nextB = (rawB >= Modulus) ? reducedB[HalfWidth-1:0] : rawB[HalfWidth-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sumA    <= '0;
            sumB    <= '0;
            bUpdate <= 1'b0;
        end else if (takeClear) begin
            // clear wins over any b update still in flight
            sumA    <= '0;
            sumB    <= '0;
            bUpdate <= 1'b0;
        end else begin
            bUpdate <= takeData;
            if (takeData) begin
                sumA <= nextA;
            end
            if (bUpdate) begin
                sumB <= nextB;
            end
        end
    end

    assign checksum = {sumB, sumA};
    // a b update still owed to the last data entry
    assign pending = bUpdate;

endmodule

//--- hw/cmdQueue.sv
`timescale 1ns/1ns
`include "fletcher_cfg.svh"

module cmdQueue
    import fletcherPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      pushValid,
    input  cmdEntry_t pushEntry,
    output logic      queueFull,
    output logic      popValid,
    output cmdEntry_t popEntry
);
    localparam int Depth      = `CMD_QUEUE_DEPTH;
    localparam int PtrWidth   = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CountWidth = $clog2(Depth + 1);

    // circular entry storage
    cmdEntry_t entries [Depth];

    logic [PtrWidth-1:0]   wrPtr;
    logic [PtrWidth-1:0]   rdPtr;
    logic [CountWidth-1:0] count;

    logic doPush;
    logic doPop;

    // wrap at depth, works for any depth
    function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
        nextPtr = (ptr == PtrWidth'(Depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign queueFull = (count == CountWidth'(Depth));
    // accumulator takes the head every cycle it is there
    assign popValid = (count != '0);
    assign popEntry = entries[rdPtr];

    assign doPush = pushValid && !queueFull;
    assign doPop  = popValid;

    // storage needs no reset
    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= pushEntry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            // occupancy holds when push and pop meet
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- hw/axiLiteRegs.sv
`timescale 1ns/1ns
`include "fletcher_cfg.svh"

module axiLiteRegs
    import fletcherPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // write address and data
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    // write response
    output axiResp_t    bresp,
    output logic        bvalid,
    input  logic        bready,
    // read address
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    // read data
    output logic [31:0] rdata,
    output axiResp_t    rresp,
    output logic        rvalid,
    input  logic        rready,
    // command queue side
    output logic        pushValid,
    output cmdEntry_t   pushEntry,
    input  logic        queueFull,
    input  logic        queueNotEmpty,
    input  logic        pending,
    input  checksum_t   checksum
);
    localparam int HalfWidth = $bits(halfWord_t);

    // write accept pulse, drives awready and wready together
    logic wrReady;
    logic wrFire;
    // CTRL or DATA, the offsets that become commands
    logic wrIsCmd;
    logic wrRoom;
    logic rdFire;
    logic busy;

    // wstrb is not decoded
    // every write is taken as a full word
    assign wrIsCmd = (awaddr == `REG_CTRL) || (awaddr == `REG_DATA);
    // unmapped writes never wait on the queue
    assign wrRoom  = !wrIsCmd || !queueFull;

    assign awready = wrReady;
    assign wready  = wrReady;
    assign wrFire  = wrReady && awvalid && wvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrReady <= 1'b0;
        end else if (wrReady) begin
            // one cycle only
            wrReady <= 1'b0;
        end else begin
            // no new accept while a response is still out
            wrReady <= awvalid && wvalid && !bvalid && wrRoom;
        end
    end

    // queue had room when the pulse was raised
    // and nothing else pushes in between
    assign pushValid = wrFire && wrIsCmd;

    always_comb begin
        pushEntry.kind = (awaddr == `REG_CTRL) ? cmdClear : cmdData;
        // low halfword of the write is the data
        pushEntry.data = wdata[HalfWidth-1:0];
    end

    // write response handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wrFire) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // response held until bready
    always_ff @(posedge clk) begin
        if (wrFire) begin
            bresp <= wrIsCmd ? respOkay : respSlvErr;
        end
    end

    // read side
    assign arready = !rvalid;
    assign rdFire  = arvalid && arready;

    // still work queued, or b not yet caught up
    assign busy = queueNotEmpty || pending;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rdFire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    // data and response captured at accept, stable while rvalid
    always_ff @(posedge clk) begin
        if (rdFire) begin
            case (araddr)
                `REG_STATUS: begin
                    rdata <= {{31{1'b0}}, busy};
                    rresp <= respOkay;
                end
                `REG_CHECKSUM: begin
                    rdata <= checksum;
                    rresp <= respOkay;
                end
                default: begin
                    // CTRL and DATA are write-only
                    rdata <= '0;
                    rresp <= respSlvErr;
                end
            endcase
        end
    end

endmodule

//--- hw/fletcherTop.sv
`timescale 1ns/1ns
`include "fletcher_cfg.svh"

module fletcherTop
    import fletcherPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output axiResp_t    bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [3:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output axiResp_t    rresp,
    output logic        rvalid,
    input  logic        rready
);
    // register block to queue
    logic      pushValid;
    cmdEntry_t pushEntry;
    logic      queueFull;

    // queue to accumulator
    logic      popValid;
    cmdEntry_t popEntry;

    // accumulator back to the register block
    checksum_t checksum;
    logic      pending;

    axiLiteRegs i_regs (
        .clk           (clk),
        .rst           (rst),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .pushValid     (pushValid),
        .pushEntry     (pushEntry),
        .queueFull     (queueFull),
        // head valid doubles as the not-empty flag
        .queueNotEmpty (popValid),
        .pending       (pending),
        .checksum      (checksum)
    );

    cmdQueue i_queue (
        .clk       (clk),
        .rst       (rst),
        .pushValid (pushValid),
        .pushEntry (pushEntry),
        .queueFull (queueFull),
        .popValid  (popValid),
        .popEntry  (popEntry)
    );

    fletcherAccumulator i_accum (
        .clk      (clk),
        .rst      (rst),
        .popValid (popValid),
        .popEntry (popEntry),
        .checksum (checksum),
        .pending  (pending)
    );

endmodule

//--- verification/fletcherTop_props.sv
`timescale 1ns/1ns

module fletcherTop_props
    import fletcherPkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        bvalid,
    input logic        bready,
    input axiResp_t    bresp,
    input logic        rvalid,
    input logic        rready,
    input axiResp_t    rresp,
    input logic [31:0] rdata,
    input logic        pushValid,
    input logic        queueFull
);
    // write response held until taken
    bHold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped or bresp changed before bready");

    // read response held with its data
    rHold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
        else $error("rvalid dropped or read data changed before rready");

    // no response straight out of reset
    resetQuiet: assert property (@(posedge clk) rst |=> !bvalid && !rvalid)
        else $error("response valid in the cycle after reset");

    // queue overflow guard
    noPushFull: assert property (@(posedge clk) disable iff (rst) pushValid |-> !queueFull)
        else $error("push into a full command queue");

endmodule

//--- verification/fletcherTb.sv
`timescale 1ns/1ns
`include "fletcher_cfg.svh"

module fletcherTb
    import fletcherPkg::*;
();
    typedef enum logic [1:0] {
        opWrite,
        opRead,
        opBurst
    } opKind_t;

    // one test row
    // value is a word count for bursts, the expected busy bit for STATUS reads
    typedef struct packed {
        opKind_t     op;
        logic [3:0]  offset;
        logic [31:0] value;
        int          stall;
        axiResp_t    expResp;
    } stimRow_t;

    logic        clk;
    logic        rst;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    axiResp_t    bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    axiResp_t    rresp;
    logic        rvalid;
    logic        rready;

    stimRow_t    stimTable[$];
    int          errorCount = 0;
    int          checkCount = 0;
    int          watchdogCycles = 0;
    logic [31:0] lcgState = 32'd68137;
    // reference sums, kept below 65535
    logic [31:0] modelA;
    logic [31:0] modelB;

    fletcherTop i_dut (
        .clk     (clk),
        .rst     (rst),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    bind fletcherTop fletcherTop_props i_props (
        .clk       (clk),
        .rst       (rst),
        .bvalid    (bvalid),
        .bready    (bready),
        .bresp     (bresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .rresp     (rresp),
        .rdata     (rdata),
        .pushValid (pushValid),
        .queueFull (queueFull)
    );

    // 20 ns period
    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic halfWord_t nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        // upper bits of an LCG are the better ones
        return lcgState[31:16];
    endfunction

    task automatic checkResp(input axiResp_t got, input axiResp_t exp, input string what);
        checkCount++;
        if (got != exp) begin
            $display("Error %0t ns: %s is %s, expected %s", $time, what, got.name(), exp.name());
            errorCount++;
        end
    endtask

    task automatic checkChecksum(input checksum_t got, input checksum_t exp, input string what);
        checkCount++;
        if (got != exp) begin
            $display("Error %0t ns: %s is 0x%h, expected 0x%h", $time, what, got, exp);
            errorCount++;
        end
    endtask

    task automatic checkBusy(input logic got, input logic exp);
        checkCount++;
        if (got !== exp) begin
            $display("Error %0t ns: busy is %b, expected %b", $time, got, exp);
            errorCount++;
        end
    endtask

    // one write, held response released after stall cycles
    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                            input int stall, output axiResp_t resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready && !wready) begin
            @(negedge clk);
        end
        // both ready lines pulse in the same cycle
        if (awready !== wready) begin
            $display("awready and wready did not rise together");
            errorCount++;
        end
        // accepted at the edge just passed
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) begin
            @(negedge clk);
        end
        repeat (stall) begin
            @(negedge clk);
            if (!bvalid) begin
                $display("write response dropped while bready was low");
                errorCount++;
            end
        end
        bready = 1'b1;
        resp   = bresp;
        @(negedge clk);
        bready = 1'b0;
        if (bvalid) begin
            $display("a second write response followed a single write");
            errorCount++;
        end
    endtask

    task automatic axiRead(input logic [3:0] addr, input int stall,
                           output axiResp_t resp, output logic [31:0] data);
        araddr  = addr;
        arvalid = 1'b1;
        // arready follows rvalid only, stable here
        while (!arready) begin
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid) begin
            @(negedge clk);
        end
        repeat (stall) begin
            @(negedge clk);
            if (!rvalid) begin
                $display("read response dropped while rready was low");
                errorCount++;
            end
        end
        rready = 1'b1;
        data   = rdata;
        resp   = rresp;
        @(negedge clk);
        rready = 1'b0;
        if (rvalid) begin
            $display("a second read response followed a single read");
            errorCount++;
        end
    endtask

    // poll STATUS until the queue and the b stage are empty
    task automatic waitIdle();
        axiResp_t    resp;
        logic [31:0] data;
        int          polls;
        polls = 0;
        data  = 32'd1;
        while (data[0] && polls < 100) begin
            axiRead(`REG_STATUS, 0, resp, data);
            polls++;
        end
        if (data[0]) begin
            $display("busy still set after %0d STATUS polls", polls);
            errorCount++;
        end
    endtask

    // checksum rule, mod 65535 on both sums
    task automatic applyModel(input logic [3:0] offset, input halfWord_t d);
        if (offset == `REG_CTRL) begin
            modelA = 32'd0;
            modelB = 32'd0;
        end else if (offset == `REG_DATA) begin
            modelA = (modelA + {16'd0, d}) % 32'd65535;
            modelB = (modelB + modelA) % 32'd65535;
        end
    endtask

    task automatic addRow(input opKind_t op, input logic [3:0] offset,
                          input logic [31:0] value, input int stall, input axiResp_t expResp);
        stimRow_t row;
        row.op      = op;
        row.offset  = offset;
        row.value   = value;
        row.stall   = stall;
        row.expResp = expResp;
        stimTable.push_back(row);
    endtask

    task automatic buildTable();
        // idle after reset
        addRow(opRead, `REG_STATUS, 32'd0, 0, respOkay);
        addRow(opRead, `REG_CHECKSUM, 32'd0, 0, respOkay);
        // 1, 2 gives a = 3, b = 4
        addRow(opWrite, `REG_CTRL, 32'd0, 0, respOkay);
        addRow(opWrite, `REG_DATA, 32'h0001, 0, respOkay);
        addRow(opWrite, `REG_DATA, 32'h0002, 0, respOkay);
        // b update still owed right after the write
        addRow(opRead, `REG_STATUS, 32'd1, 0, respOkay);
        addRow(opRead, `REG_CHECKSUM, 32'd0, 0, respOkay);
        // 0xffff wraps to zero
        addRow(opWrite, `REG_CTRL, 32'd0, 0, respOkay);
        addRow(opWrite, `REG_DATA, 32'hFFFF, 0, respOkay);
        addRow(opRead, `REG_CHECKSUM, 32'd0, 0, respOkay);
        // random burst, back to back
        addRow(opWrite, `REG_CTRL, 32'd0, 0, respOkay);
        addRow(opBurst, `REG_DATA, 32'd64, 0, respOkay);
        addRow(opRead, `REG_CHECKSUM, 32'd0, 0, respOkay);
        // clear in the middle of a stream, upper bits ignored
        addRow(opWrite, `REG_DATA, 32'hABCD1234, 0, respOkay);
        addRow(opWrite, `REG_CTRL, 32'h5A5A5A5A, 0, respOkay);
        addRow(opWrite, `REG_DATA, 32'h0005, 0, respOkay);
        addRow(opWrite, `REG_DATA, 32'h0007, 0, respOkay);
        addRow(opRead, `REG_CHECKSUM, 32'd0, 0, respOkay);
        // read-only and write-only offsets
        addRow(opWrite, `REG_STATUS, 32'h0099, 0, respSlvErr);
        addRow(opWrite, `REG_CHECKSUM, 32'h0099, 0, respSlvErr);
        addRow(opRead, `REG_CTRL, 32'd0, 0, respSlvErr);
        addRow(opRead, `REG_DATA, 32'd0, 0, respSlvErr);
        addRow(opRead, `REG_CHECKSUM, 32'd0, 0, respOkay);
        // held-off responses
        addRow(opWrite, `REG_DATA, 32'h0042, 6, respOkay);
        addRow(opRead, `REG_CHECKSUM, 32'd0, 5, respOkay);
        addRow(opRead, `REG_STATUS, 32'd0, 3, respOkay);
    endtask

    task automatic runRow(input int idx);
        stimRow_t    row;
        opKind_t     op;
        axiResp_t    resp;
        logic [31:0] data;
        halfWord_t   word;
        int          errorsBefore;
        int          i;
        row          = stimTable[idx];
        op           = row.op;
        errorsBefore = errorCount;
        if (op == opWrite) begin
            axiWrite(row.offset, row.value, row.stall, resp);
            checkResp(resp, row.expResp, "write response");
            applyModel(row.offset, row.value[15:0]);
        end else if (op == opBurst) begin
            for (i = 0; i < int'(row.value); i++) begin
                word = nextRand();
                axiWrite(row.offset, {16'd0, word}, row.stall, resp);
                checkResp(resp, row.expResp, "burst write response");
                applyModel(row.offset, word);
            end
        end else begin
            if (row.offset == `REG_CHECKSUM) begin
                waitIdle();
            end
            axiRead(row.offset, row.stall, resp, data);
            checkResp(resp, row.expResp, "read response");
            if (row.offset == `REG_CHECKSUM) begin
                checkChecksum(data, {modelB[15:0], modelA[15:0]}, "checksum");
            end else if (row.offset == `REG_STATUS) begin
                checkBusy(data[0], row.value[0]);
            end else begin
                checkChecksum(data, '0, "error read data");
            end
        end
        $display("test %0d: %s at 0x%h %s", idx, op.name(), row.offset,
                 (errorCount == errorsBefore) ? "passed" : "FAILED");
    endtask

    // cycle budget from stall lengths and burst sizes
    initial begin
        wait (watchdogCycles != 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout, tests did not finish within %0d cycles", watchdogCycles);
        $display("Errors found");
        $finish;
    end

    initial begin
        int maxStall;
        int burstWords;
        rst     = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        modelA  = 32'd0;
        modelB  = 32'd0;
        buildTable();
        maxStall   = 1;
        burstWords = 0;
        foreach (stimTable[k]) begin
            if (stimTable[k].stall > maxStall) begin
                maxStall = stimTable[k].stall;
            end
            if (stimTable[k].op == opBurst) begin
                burstWords += int'(stimTable[k].value);
            end
        end
        watchdogCycles = (stimTable.size() * maxStall + burstWords) * 40;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (stimTable[k]) begin
            runRow(k);
        end
        $display("tests: %0d, checks: %0d, errors: %0d", stimTable.size(), checkCount,
                 errorCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+hw
hw/fletcherPkg.sv
hw/fletcherAccumulator.sv
hw/cmdQueue.sv
hw/axiLiteRegs.sv
hw/fletcherTop.sv
verification/fletcherTop_props.sv
verification/fletcherTb.sv

//--- run.sh
#!/bin/sh
# build and run the Fletcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module fletcherTb -f tb.f -o simFletcher
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/simFletcher > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
